// File: build.f
logic/isq_cfg_pkg.sv
logic/isq_inst_pkg.sv
logic/isq_lin.sv
logic/isq.sv
logic/isq_age.sv
logic/isq_select.sv
logic/isq_top.sv
verif/isq_assert.sv
verif/isq_tb.sv

// File: logic/isq.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// issue queue line storage
////////////////////////////////////////////////////////////

module isq
(
   input  logic                                                  clk,
   input  logic                                                  rst_n,
   // port 0 in the low word
   input  isq_inst_pkg::inst_u [isq_cfg_pkg::INST_PORT-1:0]      inst_i,
   input  logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                     lin_en_i,
   input  logic                                                  wr_en_i,
   input  logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                     wake_i,
   input  logic                                                  flush_i,
   // one-hot line picked by the selector
   input  logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                     iss_clr_i,
   output isq_inst_pkg::isq_line_t [isq_cfg_pkg::ISQ_DEPTH-1:0] lines_o,
   output logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                     ready_o,
   output logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                     wr_vec_o
);

   import isq_cfg_pkg::*;
   import isq_inst_pkg::*;

   // lines actually written this edge
   assign wr_vec_o = lin_en_i & {ISQ_DEPTH{wr_en_i}};

   ////////////////////////////////////////////////////////////
   // per-line input build and storage
   ////////////////////////////////////////////////////////////

   genvar g;
   generate
      for (g = 0; g < ISQ_DEPTH; g = g + 1)
      begin : g_lin
         isq_line_t lin_in;

         // port select wraps every INST_PORT lines
         // wait comes straight from the dep bit
         assign lin_in = '{
            valid: 1'b1,
            wat:   inst_i[g % INST_PORT].mat.dep,
            inst:  inst_i[g % INST_PORT]
         };

         isq_lin u_lin
         (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_en_i   (wr_vec_o[g]),
            .lin_i     (lin_in),
            .clr_wat_i (wake_i[g]),
            .clr_val_i (iss_clr_i[g]),
            .fls_i     (flush_i),
            .lin_o     (lines_o[g])
         );

         // eligible once valid and no longer parked
         assign ready_o[g] = lines_o[g].valid & ~lines_o[g].wat;
      end
   endgenerate

endmodule : isq

`default_nettype wire

// File: logic/isq_age.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// age matrix
// row k, bit j set means line j went in before line k
////////////////////////////////////////////////////////////

module isq_age
(
   input  logic                                                          clk,
   input  logic                                                          rst_n,
   input  logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                             wr_vec_i,
   input  logic                                                          flush_i,
   output logic [isq_cfg_pkg::ISQ_DEPTH-1:0][isq_cfg_pkg::ISQ_DEPTH-1:0] older_o
);

   import isq_cfg_pkg::*;

   logic [ISQ_DEPTH-1:0][ISQ_DEPTH-1:0] older_q;
   logic [ISQ_DEPTH-1:0][ISQ_DEPTH-1:0] older_nxt;

   ////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int k = 0; k < ISQ_DEPTH; k++)
      begin
         for (int j = 0; j < ISQ_DEPTH; j++)
         begin
            if (wr_vec_i[k])
            begin
               // fresh line is younger than everything not written now,
               // and among same-cycle writes the lower index wins
               older_nxt[k][j] = (j != k) && (!wr_vec_i[j] || (j < k));
            end
            else
            begin
               // a rewritten line becomes the youngest
               older_nxt[k][j] = older_q[k][j] && !wr_vec_i[j];
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // state
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         older_q <= '0;
      // flush drops any write of the same cycle
      else if (flush_i)
         older_q <= '0;
      else
         older_q <= older_nxt;
   end

   // stale rows of invalid lines are harmless, selector masks by ready
   assign older_o = older_q;

endmodule : isq_age

`default_nettype wire

// File: logic/isq_cfg_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// issue window sizing
////////////////////////////////////////////////////////////

package isq_cfg_pkg;

   // lines in the issue queue
   localparam int ISQ_DEPTH = 16;

   // dispatch ports, line i takes port i mod INST_PORT
   localparam int INST_PORT = 4;

   // width of a line number
   localparam int ISQ_IDX_W = 4;

   // raw instruction word
   localparam int INST_W = 16;

endpackage : isq_cfg_pkg

`default_nettype wire

// File: logic/isq_inst_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// instruction formats and issue commands
////////////////////////////////////////////////////////////

package isq_inst_pkg;

   // top bit of every word picks the format
   typedef enum logic
   {
      KIND_MAT = 1'b0,
      KIND_VEC = 1'b1
   } inst_kind_e;

   // matrix view of a word
   typedef struct packed
   {
      inst_kind_e kind;
      logic       dep;
      logic [1:0] opcode;
      logic [5:0] row;
      logic [5:0] col;
   } mat_fmt_t;

   // vector view of the same word
   typedef struct packed
   {
      inst_kind_e kind;
      logic       dep;
      logic [1:0] opcode;
      logic [3:0] dst;
      logic [3:0] src;
      logic [3:0] imm;
   } vec_fmt_t;

   // kind and dep sit at the same bits in both views
   typedef union packed
   {
      mat_fmt_t mat;
      vec_fmt_t vec;
   } inst_u;

   // one queue line, wat is the wait bit
   typedef struct packed
   {
      logic  valid;
      logic  wat;
      inst_u inst;
   } isq_line_t;

   // issued matrix command
   typedef struct packed
   {
      logic                             valid;
      logic [isq_cfg_pkg::ISQ_IDX_W-1:0] idx;
      logic [1:0]                       opcode;
      logic [5:0]                       row;
      logic [5:0]                       col;
   } mat_cmd_t;

   // issued vector command
   typedef struct packed
   {
      logic                             valid;
      logic [isq_cfg_pkg::ISQ_IDX_W-1:0] idx;
      logic [1:0]                       opcode;
      logic [3:0]                       dst;
      logic [3:0]                       src;
      logic [3:0]                       imm;
   } vec_cmd_t;

endpackage : isq_inst_pkg

`default_nettype wire

// File: logic/isq_lin.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// single issue queue line
////////////////////////////////////////////////////////////

module isq_lin
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    wr_en_i,
   input  isq_inst_pkg::isq_line_t lin_i,
   input  logic                    clr_wat_i,
   input  logic                    clr_val_i,
   input  logic                    fls_i,
   output isq_inst_pkg::isq_line_t lin_o
);

   import isq_inst_pkg::*;

   // state bits
   logic  val_q;
   logic  wat_q;
   // payload, only meaningful while valid
   inst_u inst_q;

   // flush beats everything, then a new write
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         val_q <= 1'b0;
         wat_q <= 1'b0;
      end
      else if (fls_i)
      begin
         val_q <= 1'b0;
         wat_q <= 1'b0;
      end
      else if (wr_en_i)
      begin
         val_q <= lin_i.valid;
         // dep instructions park until woken
         wat_q <= lin_i.wat;
      end
      else
      begin
         // issued line leaves the window
         if (clr_val_i)
            val_q <= 1'b0;
         // completion wake-up
         if (clr_wat_i)
            wat_q <= 1'b0;
      end
   end

   // instruction word
   always_ff @(posedge clk)
   begin
      if (wr_en_i)
         inst_q <= lin_i.inst;
   end

   assign lin_o = '{valid: val_q, wat: wat_q, inst: inst_q};

endmodule : isq_lin

`default_nettype wire

// File: logic/isq_select.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// oldest-ready pick and command decode
////////////////////////////////////////////////////////////

module isq_select
(
   input  logic                                                          clk,
   input  logic                                                          rst_n,
   input  logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                             ready_i,
   input  isq_inst_pkg::isq_line_t [isq_cfg_pkg::ISQ_DEPTH-1:0]         lines_i,
   input  logic [isq_cfg_pkg::ISQ_DEPTH-1:0][isq_cfg_pkg::ISQ_DEPTH-1:0] older_i,
   input  logic                                                          stall_i,
   output logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                             iss_clr_o,
   output isq_inst_pkg::mat_cmd_t                                        mat_cmd_o,
   output isq_inst_pkg::vec_cmd_t                                        vec_cmd_o
);

   import isq_cfg_pkg::*;
   import isq_inst_pkg::*;

   logic [ISQ_DEPTH-1:0] pick;
   logic                 pick_any;
   logic [ISQ_IDX_W-1:0] pick_idx;
   inst_u                word;
   mat_cmd_t             mat_nxt;
   vec_cmd_t             vec_nxt;
   mat_cmd_t             mat_q;
   vec_cmd_t             vec_q;

   ////////////////////////////////////////////////////////////
   // pick
   ////////////////////////////////////////////////////////////

   // a ready line with no ready line ahead of it
   // the matrix is a total order, so at most one bit survives
   always_comb
   begin
      for (int k = 0; k < ISQ_DEPTH; k++)
         pick[k] = ready_i[k] && ((older_i[k] & ready_i) == '0) && !stall_i;
   end

   assign pick_any  = |pick;
   // back to storage, clears valid on this edge
   assign iss_clr_o = pick;

   // one-hot to index
   always_comb
   begin
      pick_idx = '0;
      for (int k = 0; k < ISQ_DEPTH; k++)
      begin
         if (pick[k])
            pick_idx = pick_idx | ISQ_IDX_W'(k);
      end
   end

   ////////////////////////////////////////////////////////////
   // decode, same word read through either view
   ////////////////////////////////////////////////////////////

   assign word = lines_i[pick_idx].inst;

   assign mat_nxt = '{
      valid:  pick_any && (word.mat.kind == KIND_MAT),
      idx:    pick_idx,
      opcode: word.mat.opcode,
      row:    word.mat.row,
      col:    word.mat.col
   };

   assign vec_nxt = '{
      valid:  pick_any && (word.vec.kind == KIND_VEC),
      idx:    pick_idx,
      opcode: word.vec.opcode,
      dst:    word.vec.dst,
      src:    word.vec.src,
      imm:    word.vec.imm
   };

   // command stage, one cycle after the pick
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mat_q <= '0;
         vec_q <= '0;
      end
      else
      begin
         mat_q <= mat_nxt;
         vec_q <= vec_nxt;
      end
   end

   assign mat_cmd_o = mat_q;
   assign vec_cmd_o = vec_q;

endmodule : isq_select

`default_nettype wire

// File: logic/isq_top.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// issue window top
////////////////////////////////////////////////////////////

module isq_top
(
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   // four words, port 0 in the low bits
   input  logic [isq_cfg_pkg::INST_PORT*isq_cfg_pkg::INST_W-1:0] inst_i,
   input  logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                    lin_en_i,
   input  logic                                                 wr_en_i,
   input  logic [isq_cfg_pkg::ISQ_DEPTH-1:0]                    wake_i,
   input  logic                                                 flush_i,
   input  logic                                                 stall_i,
   output isq_inst_pkg::mat_cmd_t                               mat_cmd_o,
   output isq_inst_pkg::vec_cmd_t                               vec_cmd_o
);

   import isq_cfg_pkg::*;
   import isq_inst_pkg::*;

   isq_line_t [ISQ_DEPTH-1:0]                lines;
   logic [ISQ_DEPTH-1:0]                     ready_vec;
   logic [ISQ_DEPTH-1:0]                     wr_vec;
   logic [ISQ_DEPTH-1:0][ISQ_DEPTH-1:0]      older_mat;
   logic [ISQ_DEPTH-1:0]                     iss_clr;

   // storage, flat word bus lands on the packed union array
   isq u_isq
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .inst_i    (inst_i),
      .lin_en_i  (lin_en_i),
      .wr_en_i   (wr_en_i),
      .wake_i    (wake_i),
      .flush_i   (flush_i),
      .iss_clr_i (iss_clr),
      .lines_o   (lines),
      .ready_o   (ready_vec),
      .wr_vec_o  (wr_vec)
   );

   // write order
   isq_age u_age
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_vec_i (wr_vec),
      .flush_i  (flush_i),
      .older_o  (older_mat)
   );

   // pick and command
   isq_select u_sel
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .ready_i   (ready_vec),
      .lines_i   (lines),
      .older_i   (older_mat),
      .stall_i   (stall_i),
      .iss_clr_o (iss_clr),
      .mat_cmd_o (mat_cmd_o),
      .vec_cmd_o (vec_cmd_o)
   );

endmodule : isq_top

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the issue window testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module isq_tb -Mdir obj_dir -f build.f || exit 1
out="$(./obj_dir/Visq_tb +verilator+error+limit+100)"
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED" && exit 0 || exit 1

// File: verif/isq_assert.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// selector properties, bound into isq_select
////////////////////////////////////////////////////////////

module isq_assert
(
   input logic                              clk,
   input logic                              rst_n,
   input logic                              stall_i,
   input logic [isq_cfg_pkg::ISQ_DEPTH-1:0] iss_clr_i,
   input isq_inst_pkg::mat_cmd_t            mat_cmd_i,
   input isq_inst_pkg::vec_cmd_t            vec_cmd_i
);

   // assertion failures so far
   int fail_cnt = 0;

   // one issue per cycle, so one command port at a time
   one_cmd_a : assert property (@(posedge clk) disable iff (!rst_n)
      !(mat_cmd_i.valid && vec_cmd_i.valid))
   else
   begin
      fail_cnt++;
      $error("matrix and vector command valid in the same cycle");
   end

   // at most one line cleared per edge
   clr_onehot_a : assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(iss_clr_i))
   else
   begin
      fail_cnt++;
      $error("issue clear vector has more than one bit set");
   end

   // stalled edge picks nothing
   stall_quiet_a : assert property (@(posedge clk) disable iff (!rst_n)
      stall_i |=> !mat_cmd_i.valid && !vec_cmd_i.valid)
   else
   begin
      fail_cnt++;
      $error("command produced in the cycle after a stall");
   end

endmodule : isq_assert

`default_nettype wire

// File: verif/isq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module isq_tb;

   import isq_cfg_pkg::*;
   import isq_inst_pkg::*;

   logic                        clk;
   logic                        rst_n;
   logic [INST_PORT*INST_W-1:0] inst;
   logic [ISQ_DEPTH-1:0]        lin_en;
   logic                        wr_en;
   logic [ISQ_DEPTH-1:0]        wake;
   logic                        flush;
   logic                        stall;
   mat_cmd_t                    mat_cmd;
   vec_cmd_t                    vec_cmd;

   // model state per line, seq is the write order
   logic [ISQ_DEPTH-1:0]        m_val;
   logic [ISQ_DEPTH-1:0]        m_wat;
   logic [INST_W-1:0]           m_inst [ISQ_DEPTH];
   int unsigned                 m_seq [ISQ_DEPTH];
   int unsigned                 seq_cnt;
   // command due one cycle after the edge
   logic                        exp_any;
   logic [ISQ_IDX_W-1:0]        exp_idx;
   logic [INST_W-1:0]           exp_word;
   logic [31:0]                 lfsr;
   int                          errors;
   int                          issued;
   int                          asrt_fails;

   always #10 clk = ~clk;

   isq_top u_dut
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .inst_i    (inst),
      .lin_en_i  (lin_en),
      .wr_en_i   (wr_en),
      .wake_i    (wake),
      .flush_i   (flush),
      .stall_i   (stall),
      .mat_cmd_o (mat_cmd),
      .vec_cmd_o (vec_cmd)
   );

   bind isq_select isq_assert u_assert
   (
      .clk       (clk),
      .rst_n     (rst_n),
      .stall_i   (stall_i),
      .iss_clr_i (iss_clr_o),
      .mat_cmd_i (mat_cmd_o),
      .vec_cmd_i (vec_cmd_o)
   );

   // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int b = 0; b < n; b++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   ////////////////////////////////////////////////////////////
   // reference model, stepped at each rising edge
   ////////////////////////////////////////////////////////////

   always @(posedge clk)
   begin : model
      int          pk;
      int unsigned best;
      if (!rst_n)
      begin
         m_val    = '0;
         m_wat    = '0;
         seq_cnt  = 0;
         exp_any  = 1'b0;
         exp_idx  = '0;
         exp_word = '0;
      end
      else
      begin
         pk   = -1;
         best = '1;
         // oldest ready line, lowest sequence number
         for (int k = 0; k < ISQ_DEPTH; k++)
         begin
            if (!stall && m_val[k] && !m_wat[k] && m_seq[k] < best)
            begin
               best = m_seq[k];
               pk   = k;
            end
         end
         exp_any = (pk >= 0);
         if (exp_any)
         begin
            exp_idx   = ISQ_IDX_W'(pk);
            exp_word  = m_inst[pk];
            m_val[pk] = 1'b0;
         end
         m_wat = m_wat & ~wake;
         // lower index gets the lower sequence number
         for (int k = 0; k < ISQ_DEPTH; k++)
         begin
            if (wr_en && lin_en[k])
            begin
               m_val[k]  = 1'b1;
               m_inst[k] = inst[(k % INST_PORT)*INST_W +: INST_W];
               m_wat[k]  = m_inst[k][14];
               m_seq[k]  = seq_cnt;
               seq_cnt++;
            end
         end
         if (flush)
            m_val = '0;
      end
   end

   task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
      if (got !== want)
      begin
         errors++;
         $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, want);
      end
   endtask

   // called on the falling edge, outputs settled since the rising one
   task automatic check_outputs();
      logic want_mat;
      logic want_vec;
      want_mat = exp_any && !exp_word[15];
      want_vec = exp_any && exp_word[15];
      compare(32'(mat_cmd.valid), 32'(want_mat), "mat valid");
      compare(32'(vec_cmd.valid), 32'(want_vec), "vec valid");
      if (want_mat)
      begin
         compare(32'(mat_cmd.idx), 32'(exp_idx), "mat index");
         compare(32'(mat_cmd.opcode), 32'(exp_word[13:12]), "mat opcode");
         compare(32'(mat_cmd.row), 32'(exp_word[11:6]), "mat row");
         compare(32'(mat_cmd.col), 32'(exp_word[5:0]), "mat col");
      end
      if (want_vec)
      begin
         compare(32'(vec_cmd.idx), 32'(exp_idx), "vec index");
         compare(32'(vec_cmd.opcode), 32'(exp_word[13:12]), "vec opcode");
         compare(32'(vec_cmd.dst), 32'(exp_word[11:8]), "vec dst");
         compare(32'(vec_cmd.src), 32'(exp_word[7:4]), "vec src");
         compare(32'(vec_cmd.imm), 32'(exp_word[3:0]), "vec imm");
      end
      if (exp_any)
         issued++;
   endtask

   task automatic idle_inputs();
      inst   = '0;
      lin_en = '0;
      wr_en  = 1'b0;
      wake   = '0;
      flush  = 1'b0;
      stall  = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   task automatic drive_cycle(input bit wr_on, input bit dep_on, input bit wake_on,
                              input bit stall_on, input bit flush_on);
      logic [31:0] r;
      @(negedge clk);
      check_outputs();
      idle_inputs();
      r     = take_bits(1);
      wr_en = wr_on & r[0];
      // only free lines, thinned to about a quarter
      r      = take_bits(16);
      lin_en = r[15:0] & ~m_val;
      r      = take_bits(16);
      lin_en = lin_en & r[15:0];
      for (int p = 0; p < INST_PORT; p++)
      begin
         r = take_bits(16);
         inst[p*INST_W +: INST_W] = r[15:0];
         if (!dep_on)
            inst[p*INST_W + 14] = 1'b0;
      end
      if (wake_on)
      begin
         r    = take_bits(16);
         wake = r[15:0];
         r    = take_bits(16);
         wake = wake & r[15:0];
      end
      r     = take_bits(2);
      stall = stall_on && (r[1:0] == 2'b00);
      r     = take_bits(5);
      flush = flush_on && (r[4:0] == 5'd0);
      // stalled flush edge, so nothing written earlier issues
      if (flush)
         stall = 1'b1;
   endtask

   // wake everything and wait until the model is empty
   // first step lets the last driven write land
   task automatic drain();
      int guard;
      guard = 0;
      do
      begin
         @(negedge clk);
         check_outputs();
         idle_inputs();
         wake = '1;
         guard++;
      end
      while ((m_val != '0 || exp_any) && guard < 200);
      if (m_val != '0 || exp_any)
      begin
         errors++;
         $display("timeout: the queue did not drain within 200 cycles at %0t ns", $time);
      end
   endtask

   initial
   begin
      clk    = 1'b0;
      rst_n  = 1'b0;
      lfsr   = 32'hf07b;
      errors = 0;
      issued = 0;
      idle_inputs();
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // quiet after reset
      repeat (20) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      // dep-free, pure write order
      repeat (300) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      drain();
      // parked lines and random wakes
      repeat (300) drive_cycle(1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
      drain();
      // stall bursts
      repeat (300) drive_cycle(1'b1, 1'b1, 1'b1, 1'b1, 1'b0);
      drain();
      // flush pulses on top
      repeat (300) drive_cycle(1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
      drain();
      repeat (20) drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      if (issued < 200)
      begin
         errors++;
         $display("too few commands issued: %0d", issued);
      end
      // bound selector properties
      asrt_fails = u_dut.u_sel.u_assert.fail_cnt;
      errors     = errors + asrt_fails;
      $display("isq_tb done: %0d commands checked, %0d assertion failures, %0d errors",
               issued, asrt_fails, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule : isq_tb

`default_nettype wire
